//--- bench/computer_assertions.sv
`timescale 1ns/1ps

module computer_assertions import acc_cpu_pkg::*; (
    input logic    clock,
    input logic    rst,
    input logic    retire,
    input logic    halted,
    input logic    mem_we,
    input decode_t dec
);

    int       fail_count = 0; // Read by the testbench watcher
    int       cycle_count;    // Cycles since previous retire or reset
    logic     rst_seen = 1'b0;

    // Cycle 1 is the S_FETCH cycle of the next instruction
    always_ff @(posedge clock) begin
        rst_seen <= rst;
        if (rst || retire) begin
            cycle_count <= 1;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    function automatic int expected_latency(instr_class_e cls);
        case (cls)
            CLS_STORE: return 4;
            CLS_CTRL:  return 3;
            default:   return 6; // ALU and LOAD
        endcase
    endfunction

    a_retire_latency: assert property (@(posedge clock) disable iff (rst)
        retire |-> cycle_count == expected_latency(dec.cls))
        else begin
            fail_count++;
            $error("retire at wrong cycle count %0d", cycle_count);
        end

    a_quiet_in_reset: assert property (@(posedge clock)
        rst_seen |-> !retire && !halted && !mem_we)
        else begin
            fail_count++;
            $error("retire, halted or mem_we high after reset");
        end

    a_halt_sticky: assert property (@(posedge clock) disable iff (rst)
        halted |=> halted)
        else begin
            fail_count++;
            $error("halted dropped without reset");
        end

    a_halt_quiet: assert property (@(posedge clock) disable iff (rst)
        halted |-> !retire && !mem_we)
        else begin
            fail_count++;
            $error("activity after halt");
        end

    a_store_one_cycle: assert property (@(posedge clock) disable iff (rst)
        mem_we |=> !mem_we)
        else begin
            fail_count++;
            $error("mem_we longer than one cycle");
        end

    a_store_retires: assert property (@(posedge clock) disable iff (rst)
        mem_we |-> retire && dec.cls == CLS_STORE)
        else begin
            fail_count++;
            $error("memory write outside a store retire");
        end

endmodule

bind computer computer_assertions computer_assertions_i (
    .clock  (clock),
    .rst    (rst),
    .retire (retire),
    .halted (halted),
    .mem_we (mem_we),
    .dec    (dec)
);

//--- bench/computer_tb.sv
`timescale 1ns/1ps

`include "acc_cpu_defines.svh"

module computer_tb import acc_cpu_pkg::*; ();

    logic  clock;
    logic  rst;
    logic  load_we;
    addr_t load_addr;
    word_t load_data;
    word_t acc;
    addr_t pc;
    logic  retire;
    logic  halted;
    logic  mem_we;
    addr_t mem_addr;
    word_t mem_wdata;

    word_t model_mem [`ACC_MEM_WORDS]; // Reference memory image
    word_t model_acc;
    addr_t model_pc;
    logic  model_halted;
    int    prog_pos;  // Next program slot
    int    seed;

    computer computer_i (
        .clock (clock), .rst (rst), .load_we (load_we), .load_addr (load_addr),
        .load_data (load_data), .acc (acc), .pc (pc), .retire (retire),
        .halted (halted), .mem_we (mem_we), .mem_addr (mem_addr), .mem_wdata (mem_wdata)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock; // 4 ns period
    end

    // Stop at the first bound assertion failure
    always @(posedge clock) begin
        if (computer_i.computer_assertions_i.fail_count != 0) begin
            $display("Bound assertion failed at %0t ns", $time);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    function automatic instr_t encode(instr_class_e cls, logic [3:0] func, addr_t addr);
        return {cls, func, addr};
    endfunction

    // Expected ALU result from the instruction set rules
    function automatic word_t alu_model(logic [3:0] op, word_t a, word_t b);
        case (op)
            4'd0:    return a + b;
            4'd1:    return a - b;
            4'd2:    return word_t'(32'(a) * 32'(b)); // Low half kept
            4'd3:    return (b == 0) ? 16'hffff : a / b;
            4'd4:    return {a[14:0], 1'b0};
            4'd5:    return {1'b0, a[15:1]};
            4'd6:    return (a << 1) | (a >> 15);
            4'd7:    return (a >> 1) | (a << 15);
            4'd8:    return a & b;
            4'd9:    return a | b;
            4'd10:   return a ^ b;
            4'd11:   return ~(a | b);
            4'd12:   return ~(a & b);
            4'd13:   return ~(a ^ b);
            4'd14:   return (a > b) ? 16'd1 : 16'd0;
            default: return (a == b) ? 16'd1 : 16'd0;
        endcase
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic fill_memory();
        for (int a = 0; a < `ACC_MEM_WORDS; a++) begin
            model_mem[a] = word_t'(a * 16'h9e37) ^ word_t'(a << 6) ^ 16'h00a5;
        end
        prog_pos = 0;
    endtask

    task automatic emit(instr_class_e cls, logic [3:0] func, addr_t addr);
        model_mem[prog_pos] = encode(cls, func, addr);
        prog_pos++;
    endtask

    task automatic step_model();
        instr_t       ins;
        instr_class_e cls;
        logic [3:0]   f;
        addr_t        ad;
        ins = model_mem[model_pc];
        cls = instr_class_e'(ins[15:14]);
        f = ins[13:10];
        ad = ins[9:0];
        model_pc = model_pc + 1'b1;
        case (cls)
            CLS_ALU:   model_acc = alu_model(f, model_acc, model_mem[ad]);
            CLS_LOAD:  model_acc = model_mem[ad];
            CLS_STORE: model_mem[ad] = model_acc;
            default: begin
                if (f == 4'd0 || (f == 4'd1 && model_acc == 0)) begin
                    model_pc = ad; // Taken jump
                end else if (f == 4'd15) begin
                    model_halted = 1'b1;
                end
            end
        endcase
    endtask

    task automatic wait_retire();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!retire) begin
            cycles++;
            if (cycles > 20) begin
                $display("Timeout: no retire within 20 cycles, pc is %h", pc);
                $display("TEST FAILED");
                $fatal(1);
            end
            @(negedge clock);
        end
    endtask

    task automatic wait_halted();
        int cycles;
        cycles = 0;
        while (!halted) begin
            cycles++;
            if (cycles > 10) begin
                $display("Timeout: halted never rose after the halt instruction");
                $display("TEST FAILED");
                $fatal(1);
            end
            @(posedge clock);
            #1;
        end
    endtask

    // Whole memory image goes in while rst is high
    task automatic load_and_reset();
        rst = 1'b1;
        for (int a = 0; a < `ACC_MEM_WORDS; a++) begin
            @(posedge clock);
            #1;
            load_we = 1'b1;
            load_addr = addr_t'(a);
            load_data = model_mem[a];
        end
        @(posedge clock);
        #1;
        load_we = 1'b0;
        repeat (8) @(posedge clock);
        #1;
        rst = 1'b0;
    endtask

    task automatic run_program();
        int     steps;
        instr_t ins;
        model_acc = '0;
        model_pc = '0;
        model_halted = 1'b0;
        steps = 0;
        load_and_reset();
        while (!model_halted) begin
            steps++;
            if (steps > 200) begin
                $display("Program ran 200 instructions without reaching halt");
                $display("TEST FAILED");
                $fatal(1);
            end
            wait_retire();
            ins = model_mem[model_pc];
            if (ins[15:14] == CLS_STORE) begin // Write seen in the retire cycle
                check_word("mem_we", word_t'(mem_we), 16'd1);
                check_word("mem_addr", word_t'(mem_addr), word_t'(ins[9:0]));
                check_word("mem_wdata", mem_wdata, model_acc);
            end
            step_model();
            @(posedge clock);
            #1;
            check_word("acc", acc, model_acc);
            check_word("pc", word_t'(pc), word_t'(model_pc));
        end
        wait_halted();
        repeat (5) @(posedge clock);
        #1;
        check_word("halted", word_t'(halted), 16'd1);
        check_word("acc", acc, model_acc);
        check_word("pc", word_t'(pc), word_t'(model_pc));
    endtask

    task automatic build_directed();
        fill_memory();
        model_mem[10'h200] = 16'h9234;
        model_mem[10'h201] = 16'h0007;
        model_mem[10'h202] = 16'h0000;
        model_mem[10'h203] = 16'h9234;
        for (int f = 0; f < 16; f++) begin // Every ALU function
            emit(CLS_LOAD, 4'd0, 10'h200);
            emit(CLS_ALU, 4'(f), 10'h201);
        end
        emit(CLS_LOAD, 4'd0, 10'h200);
        emit(CLS_ALU, ALU_DIV, 10'h202); // Divide by zero
        emit(CLS_LOAD, 4'd0, 10'h200);
        emit(CLS_ALU, ALU_EQ, 10'h203);
        emit(CLS_STORE, 4'd0, 10'h300);
        emit(CLS_LOAD, 4'd0, 10'h201);
        emit(CLS_LOAD, 4'd0, 10'h300);   // Reads back the store
        emit(CLS_CTRL, 4'd0, addr_t'(prog_pos + 2));
        emit(CLS_STORE, 4'd0, 10'h301); // Skipped
        emit(CLS_CTRL, 4'd5, 10'h000);  // No-op
        emit(CLS_CTRL, 4'd1, addr_t'(prog_pos + 2)); // Not taken
        emit(CLS_LOAD, 4'd0, 10'h202);
        emit(CLS_CTRL, 4'd1, addr_t'(prog_pos + 2)); // Taken
        emit(CLS_LOAD, 4'd0, 10'h201);
        emit(CLS_CTRL, 4'd15, 10'h000);
    endtask

    task automatic build_random();
        int r;
        int len;
        int target;
        fill_memory();
        for (int a = 10'h200; a < 10'h240; a++) begin
            r = $random(seed);
            model_mem[a] = (r[2:0] == 0) ? 16'h0000 : r[15:0]; // Some zeros for JZ
        end
        r = $random(seed);
        len = 16 + r[3:0];
        for (int i = 0; i < len - 1; i++) begin
            r = $random(seed);
            case (r[4:2])
                3'd4, 3'd5: emit(CLS_LOAD, 4'd0, addr_t'(10'h200 + r[13:9]));
                3'd6:       emit(CLS_STORE, 4'd0, addr_t'(10'h200 + r[13:9]));
                3'd7: begin
                    target = i + 1 + r[10:9]; // Forward only
                    if (target > len - 1) begin
                        target = len - 1;
                    end
                    emit(CLS_CTRL, r[11] ? 4'd1 : 4'd0, addr_t'(target));
                end
                default:    emit(CLS_ALU, r[8:5], addr_t'(10'h200 + r[13:9]));
            endcase
        end
        emit(CLS_CTRL, 4'd15, 10'h000);
    endtask

    initial begin
        seed = 56;
        rst = 1'b1;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_directed();
        run_program();
        for (int p = 0; p < 20; p++) begin
            build_random();
            run_program();
        end
        if (computer_i.computer_assertions_i.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1);
        end
    end

endmodule

//--- common/acc_cpu_defines.svh
`ifndef ACC_CPU_DEFINES_SVH
`define ACC_CPU_DEFINES_SVH

// Datapath and memory sizes
`define ACC_DATA_W    16   // Accumulator and memory word
`define ACC_ADDR_W    10   // Word address
`define ACC_MEM_WORDS 1024 // Main memory depth

// Instruction word fields
`define ACC_INSTR_W   16
`define ACC_CLASS_W   2
`define ACC_FUNC_W    4
`define ACC_CLASS_LSB 14   // Class in bits 15:14
`define ACC_FUNC_LSB  10   // Function in bits 13:10
`define ACC_ADDR_LSB  0    // Address in bits 9:0

// Function codes of the control class
`define ACC_CTRL_JMP  4'd0  // Unconditional jump
`define ACC_CTRL_JZ   4'd1  // Jump if accumulator is zero
`define ACC_CTRL_HALT 4'd15 // Stop until reset

`endif

//--- common/acc_cpu_pkg.sv
`include "acc_cpu_defines.svh"

package acc_cpu_pkg;

    typedef logic [`ACC_DATA_W-1:0]  word_t;  // Data word
    typedef logic [`ACC_ADDR_W-1:0]  addr_t;  // Memory address
    typedef logic [`ACC_INSTR_W-1:0] instr_t; // Raw instruction

    typedef enum logic [`ACC_CLASS_W-1:0] {
        CLS_ALU   = 2'd0, // acc = acc op mem
        CLS_LOAD  = 2'd1, // acc = mem
        CLS_STORE = 2'd2, // mem = acc
        CLS_CTRL  = 2'd3  // Jumps and halt
    } instr_class_e;

    // ALU opcode encoding
    typedef enum logic [`ACC_FUNC_W-1:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_MUL  = 4'b0010,
        ALU_DIV  = 4'b0011,
        ALU_SHL  = 4'b0100,
        ALU_SHR  = 4'b0101,
        ALU_ROL  = 4'b0110,
        ALU_ROR  = 4'b0111,
        ALU_AND  = 4'b1000,
        ALU_OR   = 4'b1001,
        ALU_XOR  = 4'b1010,
        ALU_NOR  = 4'b1011,
        ALU_NAND = 4'b1100,
        ALU_XNOR = 4'b1101,
        ALU_GT   = 4'b1110,
        ALU_EQ   = 4'b1111
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH,      // MAR <= PC
        S_FETCH_WAIT, // Memory read latency
        S_DECODE,     // IR <= rdata and PC update
        S_OPER,       // Operand access or store
        S_OPER_WAIT,  // MBR <= rdata
        S_WRITEBACK,  // ACC update
        S_HALT
    } ctrl_state_e;

    typedef struct packed {
        instr_class_e cls;
        alu_op_e      func;
        addr_t        addr;
        logic         mar_from_pc;  // MAR <= PC
        logic         mar_from_ir;  // MAR <= address field
        logic         mbr_load;     // MBR <= memory read data
        logic         acc_load;     // ACC update enable
        logic         acc_from_alu; // ALU result else MBR into ACC
        logic         mem_write;    // Store accumulator
    } decode_t;

endpackage

//--- control/control_unit.sv
`timescale 1ns/1ps

`include "acc_cpu_defines.svh"

module control_unit import acc_cpu_pkg::*; (
    input  logic    clock,
    input  logic    rst,
    input  word_t   rdata,    // Memory read data
    input  logic    acc_zero, // Accumulator equals zero
    output decode_t dec,
    output addr_t   pc,
    output logic    retire,   // Last cycle of an instruction
    output logic    halted
);

    ctrl_state_e state;
    ctrl_state_e state_next;
    instr_t      ir;
    instr_t      cur_instr;  // Instruction seen by decode
    logic [`ACC_FUNC_W-1:0] cur_func;
    instr_class_e           cur_cls;
    addr_t                  cur_addr;
    logic        is_halt;
    logic        jump_taken;

    // IR is loaded at the end of S_DECODE, so decode reads memory directly then
    assign cur_instr = (state == S_DECODE) ? instr_t'(rdata) : ir;
    assign cur_cls   = instr_class_e'(cur_instr[`ACC_CLASS_LSB +: `ACC_CLASS_W]);
    assign cur_func  = cur_instr[`ACC_FUNC_LSB +: `ACC_FUNC_W];
    assign cur_addr  = cur_instr[`ACC_ADDR_LSB +: `ACC_ADDR_W];

    assign is_halt = (cur_cls == CLS_CTRL) && (cur_func == `ACC_CTRL_HALT);

    always_comb begin
        jump_taken = 1'b0;
        if (cur_cls == CLS_CTRL) begin
            if (cur_func == `ACC_CTRL_JMP) begin
                jump_taken = 1'b1;
            end else if (cur_func == `ACC_CTRL_JZ) begin
                jump_taken = acc_zero; // Only branch condition
            end
        end
    end

    // State register
    always_ff @(posedge clock) begin
        if (rst) begin
            state <= S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_FETCH:      state_next = S_FETCH_WAIT;
            S_FETCH_WAIT: state_next = S_DECODE;
            S_DECODE: begin
                if (cur_cls == CLS_CTRL) begin
                    state_next = is_halt ? S_HALT : S_FETCH; // Control retires here
                end else begin
                    state_next = S_OPER;
                end
            end
            S_OPER:       state_next = (cur_cls == CLS_STORE) ? S_FETCH : S_OPER_WAIT;
            S_OPER_WAIT:  state_next = S_WRITEBACK;
            S_WRITEBACK:  state_next = S_FETCH;
            S_HALT:       state_next = S_HALT; // Left only by reset
            default:      state_next = S_FETCH;
        endcase
    end

    // Program counter
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (state == S_DECODE) begin
            pc <= jump_taken ? cur_addr : pc + addr_t'(1);
        end
    end

    // Instruction register
    always_ff @(posedge clock) begin
        if (state == S_DECODE) begin
            ir <= instr_t'(rdata);
        end
    end

    // Fields and per-state strobes
    always_comb begin
        dec              = '0;
        dec.cls          = cur_cls;
        dec.func         = alu_op_e'(cur_func);
        dec.addr         = cur_addr;
        dec.mar_from_pc  = (state == S_FETCH);
        // Address field into MAR early so a store can write in S_OPER
        dec.mar_from_ir  = (state == S_DECODE) ||
                           ((state == S_OPER) && (cur_cls != CLS_STORE));
        dec.mbr_load     = (state == S_OPER_WAIT);
        dec.acc_load     = (state == S_WRITEBACK);
        dec.acc_from_alu = (state == S_WRITEBACK) && (cur_cls == CLS_ALU);
        dec.mem_write    = (state == S_OPER) && (cur_cls == CLS_STORE);
    end

    always_comb begin
        case (state)
            S_DECODE:    retire = (cur_cls == CLS_CTRL);  // 3 cycles
            S_OPER:      retire = (cur_cls == CLS_STORE); // 4 cycles
            S_WRITEBACK: retire = 1'b1;                   // 6 cycles
            default:     retire = 1'b0;
        endcase
    end

    assign halted = (state == S_HALT);

endmodule

//--- sim.f
+incdir+common
common/acc_cpu_pkg.sv
src/alu.sv
src/main_memory.sv
control/control_unit.sv
src/result_path.sv
src/computer.sv
bench/computer_assertions.sv
bench/computer_tb.sv

//--- src/alu.sv
`timescale 1ns/1ps

`include "acc_cpu_defines.svh"

module alu import acc_cpu_pkg::*; (
    input  alu_op_e op,
    input  word_t   operand_a, // Accumulator
    input  word_t   operand_b, // Memory buffer
    output word_t   result
);

    word_t product; // Truncated product
    word_t quotient;

    assign product = operand_a * operand_b; // Upper half dropped

    // Divide by zero saturates to all ones
    assign quotient = (operand_b == '0) ? '1 : operand_a / operand_b;

    always_comb begin
        case (op)
            ALU_ADD:  result = operand_a + operand_b;
            ALU_SUB:  result = operand_a - operand_b;
            ALU_MUL:  result = product;
            ALU_DIV:  result = quotient;
            ALU_SHL:  result = operand_a << 1;  // Accumulator only
            ALU_SHR:  result = operand_a >> 1;
            ALU_ROL:  result = {operand_a[`ACC_DATA_W-2:0], operand_a[`ACC_DATA_W-1]};
            ALU_ROR:  result = {operand_a[0], operand_a[`ACC_DATA_W-1:1]};
            ALU_AND:  result = operand_a & operand_b;
            ALU_OR:   result = operand_a | operand_b;
            ALU_XOR:  result = operand_a ^ operand_b;
            ALU_NOR:  result = ~(operand_a | operand_b);
            ALU_NAND: result = ~(operand_a & operand_b);
            ALU_XNOR: result = ~(operand_a ^ operand_b);
            ALU_GT:   result = (operand_a > operand_b) ? word_t'(1) : word_t'(0); // Unsigned
            ALU_EQ:   result = (operand_a == operand_b) ? word_t'(1) : word_t'(0);
            default:  result = '0;
        endcase
    end

endmodule

//--- src/computer.sv
`timescale 1ns/1ps

`include "acc_cpu_defines.svh"

module computer import acc_cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst,
    input  logic  load_we,   // Program load, used while rst is high
    input  addr_t load_addr,
    input  word_t load_data,
    output word_t acc,
    output addr_t pc,
    output logic  retire,
    output logic  halted,
    output logic  mem_we,    // CPU side memory write
    output addr_t mem_addr,
    output word_t mem_wdata
);

    decode_t dec;
    word_t   rdata;
    word_t   mbr;
    word_t   alu_result;
    logic    acc_zero;
    addr_t   ram_addr;  // After load port mux
    word_t   ram_wdata;
    logic    ram_we;

    // Load port owns the memory during reset
    always_comb begin
        if (rst) begin
            ram_addr  = load_addr;
            ram_wdata = load_data;
            ram_we    = load_we;
        end else begin
            ram_addr  = mem_addr;
            ram_wdata = mem_wdata;
            ram_we    = mem_we;
        end
    end

    main_memory main_memory_i (
        .clock (clock),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (rdata)
    );

    control_unit control_unit_i (
        .clock    (clock),
        .rst      (rst),
        .rdata    (rdata),
        .acc_zero (acc_zero),
        .dec      (dec),
        .pc       (pc),
        .retire   (retire),
        .halted   (halted)
    );

    alu alu_i (
        .op        (dec.func),
        .operand_a (acc),
        .operand_b (mbr),
        .result    (alu_result)
    );

    result_path result_path_i (
        .clock      (clock),
        .rst        (rst),
        .dec        (dec),
        .pc         (pc),
        .rdata      (rdata),
        .alu_result (alu_result),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .acc        (acc),
        .mbr        (mbr),
        .acc_zero   (acc_zero)
    );

endmodule

//--- src/main_memory.sv
`timescale 1ns/1ps

`include "acc_cpu_defines.svh"

module main_memory import acc_cpu_pkg::*; (
    input  logic  clock,
    input  addr_t addr,
    input  word_t wdata,
    input  logic  we,
    output word_t rdata  // Valid one cycle after addr
);

    word_t mem [`ACC_MEM_WORDS]; // Word addressed storage

    // Read data holds during a write
    always_ff @(posedge clock) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr]; // Registered read
        end
    end

endmodule

//--- src/result_path.sv
`timescale 1ns/1ps

`include "acc_cpu_defines.svh"

module result_path import acc_cpu_pkg::*; (
    input  logic    clock,
    input  logic    rst,
    input  decode_t dec,
    input  addr_t   pc,
    input  word_t   rdata,      // Memory read data
    input  word_t   alu_result,
    output addr_t   mem_addr,
    output word_t   mem_wdata,
    output logic    mem_we,
    output word_t   acc,
    output word_t   mbr,
    output logic    acc_zero
);

    addr_t mar;
    addr_t mar_next;
    word_t acc_next;

    // MAR source select
    always_comb begin
        mar_next = mar;
        if (dec.mar_from_pc) begin
            mar_next = pc; // Instruction fetch
        end else if (dec.mar_from_ir) begin
            mar_next = dec.addr; // Operand address
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            mar <= '0;
        end else begin
            mar <= mar_next;
        end
    end

    // Operand from memory
    always_ff @(posedge clock) begin
        if (dec.mbr_load) begin
            mbr <= rdata;
        end
    end

    // ALU result for the ALU class and MBR for LOAD
    assign acc_next = dec.acc_from_alu ? alu_result : mbr;

    always_ff @(posedge clock) begin
        if (rst) begin
            acc <= '0;
        end else if (dec.acc_load) begin
            acc <= acc_next;
        end
    end

    assign acc_zero = (acc == {`ACC_DATA_W{1'b0}}); // Feeds jump-if-zero

    // Memory side
    assign mem_addr  = mar;
    assign mem_wdata = acc;           // Only stores write
    assign mem_we    = dec.mem_write;

endmodule
